// ==== Bender.yml ====
package:
  name: v33_core

export_include_dirs:
  - verilog

sources:
  - verilog/v33_pkg.sv
  - verilog/v33_decode.sv
  - verilog/v33_execute.sv
  - verilog/v33_writeback.sv
  - verilog/v33_core.sv
  - target: test
    files:
      - verification/v33_core_tb.sv

// ==== filelist.f ====
+incdir+verilog
verilog/v33_pkg.sv
verilog/v33_decode.sv
verilog/v33_execute.sv
verilog/v33_writeback.sv
verilog/v33_core.sv
verification/v33_core_tb.sv

// ==== verification/v33_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "v33_params.svh"

module v33_core_tb;

    localparam int W = `V33_DATA_W;

    logic             clk;
    logic             reset;
    logic             instr_valid;
    v33_pkg::instr_t  instr;
    logic             retire_valid;
    v33_pkg::retire_t retire;

    // Architectural model, advanced as instructions are issued
    logic [W-1:0]     m_regs [`V33_NUM_REGS];
    v33_pkg::flags_t  m_flags;
    logic [W-1:0]     m_pc;
    v33_pkg::retire_t exp_q [$];

    int errors;
    int sent;
    int retired;
    int test_no;
    int err_at_start;
    int sent_at_start;
    int ret_at_start;

    v33_core dut_i (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic cond_holds(input v33_pkg::flags_t f, input logic [3:0] c);
        logic lt;
        logic r;
        lt = f.s ^ f.v;
        case (c[3:1])      // Odd codes negate the even one below
            3'd0: r = f.v;
            3'd1: r = f.cy;
            3'd2: r = f.z;
            3'd3: r = f.cy | f.z;
            3'd4: r = f.s;
            3'd5: r = f.p;
            3'd6: r = lt;
            default: r = lt | f.z;
        endcase
        return c[0] ? !r : r;
    endfunction

    function automatic v33_pkg::retire_t ref_step(input v33_pkg::instr_t w);
        v33_pkg::retire_t r;
        int           cls;
        int           op;
        int           bits;
        int           half;
        int           sa;
        int           sb;
        int           rd;
        int           rs;
        logic         d_hi;
        logic         s_hi;
        logic         bad;
        logic         write;
        logic         taken;
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] res;
        logic [W-1:0] word;
        cls  = w.opclass;
        op   = w.alu_op;
        bits = w.wide ? W : 8;
        half = 1 << (bits - 1);
        bad  = (cls > 4) || (cls == 2 && op > 5);
        rd   = w.wide ? w.opnd.regs.reg_d : w.opnd.regs.reg_d % 4;
        rs   = w.wide ? w.opnd.regs.reg_s : w.opnd.regs.reg_s % 4;
        d_hi = !w.wide && w.opnd.regs.reg_d >= 4;
        s_hi = !w.wide && w.opnd.regs.reg_s >= 4;
        a    = w.wide ? m_regs[rd] : (d_hi ? m_regs[rd] >> 8 : m_regs[rd] & 16'hff);
        if (w.use_imm)
            b = w.wide ? w.imm : w.imm & 16'hff;
        else
            b = w.wide ? m_regs[rs] : (s_hi ? m_regs[rs] >> 8 : m_regs[rs] & 16'hff);
        write = 1'b0;
        taken = 1'b0;
        res   = b;
        if (!bad) begin
            case (cls)
                1: write = 1'b1;
                2: begin
                    sa = (a >= half) ? int'(a) - 2 * half : int'(a);  // Signed view
                    sb = (b >= half) ? int'(b) - 2 * half : int'(b);
                    m_flags.cy = 1'b0;
                    m_flags.v  = 1'b0;
                    case (op)
                        0: begin
                            res        = a + b;
                            m_flags.cy = (int'(a) + int'(b)) >= 2 * half;
                            m_flags.v  = (sa + sb >= half) || (sa + sb < -half);
                        end
                        1, 5: begin
                            res        = a - b;
                            m_flags.cy = a < b;
                            m_flags.v  = (sa - sb >= half) || (sa - sb < -half);
                        end
                        2: res = a & b;
                        3: res = a | b;
                        default: res = a ^ b;
                    endcase
                    if (bits == 8)
                        res[W-1:8] = '0;
                    m_flags.z = res == '0;
                    m_flags.s = res[bits-1];
                    m_flags.p = ~^res[7:0];
                    write     = op != 5;   // CMP
                end
                3: taken = 1'b1;
                4: taken = cond_holds(m_flags, w.opnd.br.cond);
                default: ;
            endcase
        end
        if (write) begin
            word = m_regs[rd];
            if (w.wide)
                word = res;
            else if (d_hi)
                word[W-1:8] = res[7:0];
            else
                word[7:0] = res[7:0];
            m_regs[rd] = word;
        end
        m_pc = taken ? m_pc + 4 + w.imm : m_pc + 4;
        r.reg_written = write;
        r.reg_index   = rd;
        r.reg_value   = m_regs[rd];
        r.flags       = m_flags;
        r.pc          = m_pc;
        r.illegal     = bad;
        return r;
    endfunction

    function automatic v33_pkg::instr_t make_instr(input logic [2:0] cls, input logic [2:0] op,
                                                   input logic wide, input logic use_imm,
                                                   input logic [2:0] rd, input logic [2:0] rs,
                                                   input logic [W-1:0] imm);
        v33_pkg::instr_t w;
        w                  = '0;
        w.opclass          = cls;
        w.alu_op           = op;
        w.wide             = wide;
        w.use_imm          = use_imm;
        w.opnd.regs.reg_d  = rd;
        w.opnd.regs.reg_s  = rs;
        w.imm              = imm;
        return w;
    endfunction

    function automatic v33_pkg::instr_t make_branch(input logic [2:0] cls, input logic [3:0] c,
                                                    input logic [W-1:0] imm);
        v33_pkg::instr_t w;
        w              = '0;
        w.opclass      = cls;
        w.wide         = 1'b1;
        w.opnd.br.cond = c;
        w.imm          = imm;
        return w;
    endfunction

    function automatic v33_pkg::instr_t rand_alu();
        return make_instr(v33_pkg::OP_ALU, $urandom_range(0, 5), $urandom_range(0, 1),
                          $urandom_range(0, 1), $urandom_range(0, 7), $urandom_range(0, 7),
                          $urandom);
    endfunction

    function automatic v33_pkg::instr_t rand_illegal();
        v33_pkg::instr_t w;
        w = $urandom;
        if ($urandom_range(0, 1)) begin
            w.opclass = $urandom_range(5, 7);
        end else begin
            w.opclass = v33_pkg::OP_ALU;
            w.alu_op  = $urandom_range(6, 7);
        end
        return w;
    endfunction

    function automatic v33_pkg::instr_t rand_any();
        int pick;
        pick = $urandom_range(0, 9);
        if (pick == 0)
            return make_instr(v33_pkg::OP_NOP, 0, 1, 0, 0, 0, 0);
        else if (pick <= 2)
            return make_instr(v33_pkg::OP_MOV, 0, $urandom_range(0, 1), $urandom_range(0, 1),
                              $urandom_range(0, 7), $urandom_range(0, 7), $urandom);
        else if (pick <= 6)
            return rand_alu();
        else if (pick == 7)
            return make_branch(v33_pkg::OP_BR_REL, 0, $urandom);
        else if (pick == 8)
            return make_branch(v33_pkg::OP_B_COND, $urandom_range(0, 15), $urandom);
        return rand_illegal();
    endfunction

    task automatic log_mismatch(input string name, input logic [W-1:0] got,
                                input logic [W-1:0] exp);
        $display("ERR %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic check_value(input v33_pkg::retire_t got, input v33_pkg::retire_t exp);
        if (got.reg_written !== exp.reg_written)
            log_mismatch("retire.reg_written", got.reg_written, exp.reg_written);
        if (got.reg_index !== exp.reg_index)
            log_mismatch("retire.reg_index", got.reg_index, exp.reg_index);
        if (got.reg_value !== exp.reg_value)
            log_mismatch("retire.reg_value", got.reg_value, exp.reg_value);
        if (got.pc !== exp.pc)
            log_mismatch("retire.pc", got.pc, exp.pc);
        if (got.illegal !== exp.illegal)
            log_mismatch("retire.illegal", got.illegal, exp.illegal);
    endtask

    task automatic check_flags(input v33_pkg::flags_t got, input v33_pkg::flags_t exp);
        if (got !== exp) begin
            $display("ERR retire.flags (z s p cy v): got %h expected %h", got, exp);
            errors++;
        end
    endtask

    // Outputs settle on the rising edge, sampled half a cycle later
    always @(negedge clk) begin
        v33_pkg::retire_t expected;
        if (!reset && retire_valid) begin
            if (exp_q.size() == 0) begin
                $display("retire_valid seen with no instruction outstanding");
                errors++;
            end else begin
                expected = exp_q.pop_front();
                check_value(retire, expected);
                check_flags(retire.flags, expected.flags);
            end
            retired++;
        end
    end

    task automatic send_instr(input v33_pkg::instr_t w);
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr       = w;
        exp_q.push_back(ref_step(w));
        sent++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: %s", what);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > 50)
                timeout_fail("instructions in flight never retired");
        end
    endtask

    task automatic begin_test();
        test_no++;
        err_at_start  = errors;
        sent_at_start = sent;
        ret_at_start  = retired;
    endtask

    task automatic end_test(input string name);
        idle_cycle();
        wait_drain();
        if (retired - ret_at_start != sent - sent_at_start) begin
            $display("%s: retired count does not match instructions sent", name);
            errors++;
        end
        $display("test %0d %-8s sent %0d retired %0d errors %0d", test_no, name,
                 sent - sent_at_start, retired - ret_at_start, errors - err_at_start);
    endtask

    initial begin
        int   i;
        int   c;
        int   k;
        int   n;
        logic seen;
        void'($urandom(32'hb4ef98f7));
        errors      = 0;
        sent        = 0;
        retired     = 0;
        test_no     = 0;
        instr_valid = 1'b0;
        instr       = '0;
        reset       = 1'b1;
        for (i = 0; i < `V33_NUM_REGS; i++)
            m_regs[i] = '0;
        m_flags = '0;
        m_pc    = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // NOP latency straight after reset
        begin_test();
        repeat (4) idle_cycle();
        send_instr(make_instr(v33_pkg::OP_NOP, 0, 1, 0, 0, 0, 0));
        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            idle_cycle();
            n++;
            @(negedge clk);
            seen = retire_valid;
            if (n > 10)
                timeout_fail("first NOP never retired");
        end
        if (n != `V33_LATENCY) begin
            $display("NOP retired %0d cycles after issue, expected %0d", n, `V33_LATENCY);
            errors++;
        end
        end_test("nop");

        begin_test();
        for (i = 0; i < 8; i++)
            send_instr(make_instr(v33_pkg::OP_MOV, 0, 1, 1, i, 0, $urandom));
        for (i = 0; i < 8; i++)
            send_instr(make_instr(v33_pkg::OP_MOV, 0, 0, 1, i, 0, $urandom));
        for (i = 0; i < 8; i++)
            send_instr(make_instr(v33_pkg::OP_MOV, 0, 0, 0, i, 7 - i, 0)); // AL <- BH etc
        end_test("mov");

        begin_test();
        for (i = 0; i < 400; i++)
            send_instr(rand_alu());
        end_test("alu");

        begin_test();
        for (c = 0; c < 16; c++) begin
            for (k = 0; k < 6; k++) begin
                if (k == 0)
                    send_instr(make_instr(v33_pkg::OP_ALU, v33_pkg::ALU_XOR, 1, 0, c, c, 0));
                else
                    send_instr(rand_alu());
                send_instr(make_branch(v33_pkg::OP_B_COND, c, $urandom));
            end
            send_instr(make_branch(v33_pkg::OP_BR_REL, 0, $urandom));
        end
        end_test("branch");

        begin_test();
        for (i = 0; i < 100; i++) begin
            if (i % 10 == 0)
                send_instr(rand_alu());
            send_instr(rand_illegal());
        end
        end_test("illegal");

        begin_test();
        k = 0;
        while (k < 2000) begin
            if ($urandom_range(0, 3) == 0) begin
                idle_cycle();
            end else begin
                send_instr(rand_any());
                k++;
            end
        end
        end_test("mixed");

        $display("%0d tests, %0d sent, %0d retired, %0d errors", test_no, sent, retired, errors);
        if (errors == 0 && retired == sent) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/v33_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "v33_params.svh"

module v33_core (
    input  logic             clk,
    input  logic             reset,
    input  logic             instr_valid,
    input  v33_pkg::instr_t  instr,
    output logic             retire_valid,
    output v33_pkg::retire_t retire
);

    logic                                     dec_valid;
    v33_pkg::decoded_t                        dec_op;
    logic                                     ex_valid;
    v33_pkg::exec_result_t                    ex_res;
    logic [`V33_NUM_REGS-1:0][`V33_DATA_W-1:0] regs;   // committed state
    v33_pkg::flags_t                          flags;
    logic [`V33_DATA_W-1:0]                   pc;

    v33_decode decode_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op)
    );

    v33_execute execute_i (
        .clk       (clk),
        .reset     (reset),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .regs      (regs),
        .flags     (flags),
        .pc        (pc),
        .ex_valid  (ex_valid),
        .ex_res    (ex_res)
    );

    v33_writeback writeback_i (
        .clk          (clk),
        .reset        (reset),
        .ex_valid     (ex_valid),
        .ex_res       (ex_res),
        .regs         (regs),
        .flags        (flags),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// ==== verilog/v33_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "v33_params.svh"

module v33_decode (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    input  v33_pkg::instr_t   instr,
    output logic              dec_valid,
    output v33_pkg::decoded_t dec_op
);

    v33_pkg::decoded_t next_op;
    logic              bad_class;
    logic              bad_alu;
    logic              is_data;

    assign bad_class = instr.opclass > v33_pkg::OP_B_COND;
    assign bad_alu   = (instr.opclass == v33_pkg::OP_ALU) && (instr.alu_op > v33_pkg::ALU_CMP);
    assign is_data   = (instr.opclass == v33_pkg::OP_MOV) || (instr.opclass == v33_pkg::OP_ALU);

    always_comb begin
        next_op.opclass = v33_pkg::opclass_e'(instr.opclass);
        next_op.alu_op  = v33_pkg::alu_op_e'(instr.alu_op);
        next_op.wide    = instr.wide;
        next_op.use_imm = instr.use_imm;
        next_op.cond    = instr.opnd.br.cond;
        next_op.imm     = instr.imm;
        next_op.illegal = 1'b0;

        if (instr.wide) begin
            next_op.rd    = instr.opnd.regs.reg_d;
            next_op.rd_hi = 1'b0;
            next_op.rs    = instr.opnd.regs.reg_s;
            next_op.rs_hi = 1'b0;
        end else begin
            // AL..BL are the low halves of AW..BW, AH..BH the high halves
            next_op.rd    = {1'b0, instr.opnd.regs.reg_d[1:0]};
            next_op.rd_hi = instr.opnd.regs.reg_d[2];
            next_op.rs    = {1'b0, instr.opnd.regs.reg_s[1:0]};
            next_op.rs_hi = instr.opnd.regs.reg_s[2];
            if (is_data) begin
                next_op.imm = {{(`V33_DATA_W-8){1'b0}}, instr.imm[7:0]};
            end
        end

        if (bad_class || bad_alu) begin
            next_op.opclass = v33_pkg::OP_NOP; // retires with pc + 4 only
            next_op.illegal = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        dec_op <= next_op;
    end

    // Reserved encodings must never reach execute as a writing op
    illegal_is_nop: assert property (
        @(posedge clk) disable iff (reset)
        dec_valid && dec_op.illegal |-> dec_op.opclass == v33_pkg::OP_NOP
    );

endmodule

`default_nettype wire

// ==== verilog/v33_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "v33_params.svh"

module v33_execute (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     dec_valid,
    input  v33_pkg::decoded_t                        dec_op,
    input  logic [`V33_NUM_REGS-1:0][`V33_DATA_W-1:0] regs,
    input  v33_pkg::flags_t                          flags,
    input  logic [`V33_DATA_W-1:0]                   pc,
    output logic                                     ex_valid,
    output v33_pkg::exec_result_t                    ex_res
);

    localparam int W = `V33_DATA_W;

    // Committed word, with the uncommitted result one stage ahead merged in
    function automatic logic [W-1:0] read_reg(input logic [W-1:0]          committed,
                                              input logic                  hit,
                                              input v33_pkg::exec_result_t res);
        logic [W-1:0] word;
        word = committed;
        if (hit) begin
            if (res.wide)
                word = res.result;
            else if (res.rd_hi)
                word[W-1:8] = res.result[7:0];
            else
                word[7:0] = res.result[7:0];
        end
        return word;
    endfunction

    logic [W-1:0]          d_word;
    logic [W-1:0]          s_word;
    logic [7:0]            d_byte;
    logic [7:0]            s_byte;
    logic [W-1:0]          op_a;
    logic [W-1:0]          op_b;
    logic [W-1:0]          cur_pc;
    v33_pkg::flags_t       cur_flags;
    logic [W:0]            sum;
    logic [W:0]            diff;
    logic [W-1:0]          alu_out;
    logic [W-1:0]          alu_sized;
    logic                  msb_a;
    logic                  msb_b;
    logic                  msb_r;
    v33_pkg::flags_t       alu_flags;
    logic                  cond_ok;
    v33_pkg::exec_result_t next_res;

    assign d_word = read_reg(regs[dec_op.rd], ex_valid && ex_res.wr_en && ex_res.rd == dec_op.rd,
                             ex_res);
    assign s_word = read_reg(regs[dec_op.rs], ex_valid && ex_res.wr_en && ex_res.rd == dec_op.rs,
                             ex_res);
    assign d_byte = dec_op.rd_hi ? d_word[W-1:8] : d_word[7:0];
    assign s_byte = dec_op.rs_hi ? s_word[W-1:8] : s_word[7:0];
    assign op_a   = dec_op.wide ? d_word : {{(W-8){1'b0}}, d_byte};
    assign op_b   = dec_op.use_imm ? dec_op.imm :
                    dec_op.wide ? s_word : {{(W-8){1'b0}}, s_byte};

    assign cur_flags = (ex_valid && ex_res.flags_wr) ? ex_res.flags : flags;
    // PC of this instruction, following the one still in writeback
    assign cur_pc = !ex_valid       ? pc :
                    ex_res.br_taken ? ex_res.br_target : pc + W'(4);

    assign sum  = {1'b0, op_a} + {1'b0, op_b};
    assign diff = {1'b0, op_a} - {1'b0, op_b};

    always_comb begin
        case (dec_op.alu_op)
            v33_pkg::ALU_SUB, v33_pkg::ALU_CMP: alu_out = diff[W-1:0];
            v33_pkg::ALU_AND: alu_out = op_a & op_b;
            v33_pkg::ALU_OR:  alu_out = op_a | op_b;
            v33_pkg::ALU_XOR: alu_out = op_a ^ op_b;
            default:          alu_out = sum[W-1:0];
        endcase
        alu_sized = dec_op.wide ? alu_out : {{(W-8){1'b0}}, alu_out[7:0]};
        msb_a     = dec_op.wide ? op_a[W-1] : op_a[7];
        msb_b     = dec_op.wide ? op_b[W-1] : op_b[7];
        msb_r     = dec_op.wide ? alu_out[W-1] : alu_out[7];

        alu_flags.z  = alu_sized == '0;
        alu_flags.s  = msb_r;
        alu_flags.p  = ~^alu_out[7:0];
        alu_flags.cy = 1'b0;               // logic ops clear CY and V
        alu_flags.v  = 1'b0;
        if (dec_op.alu_op == v33_pkg::ALU_ADD) begin
            alu_flags.cy = dec_op.wide ? sum[W] : sum[8];
            alu_flags.v  = (msb_a == msb_b) && (msb_r != msb_a);
        end else if (dec_op.alu_op == v33_pkg::ALU_SUB || dec_op.alu_op == v33_pkg::ALU_CMP) begin
            alu_flags.cy = dec_op.wide ? diff[W] : diff[8];     // borrow
            alu_flags.v  = (msb_a != msb_b) && (msb_r != msb_a);
        end
    end

    always_comb begin
        case (dec_op.cond)
            4'h0: cond_ok = cur_flags.v;
            4'h1: cond_ok = ~cur_flags.v;
            4'h2: cond_ok = cur_flags.cy;
            4'h3: cond_ok = ~cur_flags.cy;
            4'h4: cond_ok = cur_flags.z;
            4'h5: cond_ok = ~cur_flags.z;
            4'h6: cond_ok = cur_flags.cy | cur_flags.z;          // NH
            4'h7: cond_ok = ~(cur_flags.cy | cur_flags.z);       // H
            4'h8: cond_ok = cur_flags.s;
            4'h9: cond_ok = ~cur_flags.s;
            4'ha: cond_ok = cur_flags.p;
            4'hb: cond_ok = ~cur_flags.p;
            4'hc: cond_ok = cur_flags.s ^ cur_flags.v;           // LT
            4'hd: cond_ok = ~(cur_flags.s ^ cur_flags.v);
            4'he: cond_ok = (cur_flags.s ^ cur_flags.v) | cur_flags.z;
            4'hf: cond_ok = ~((cur_flags.s ^ cur_flags.v) | cur_flags.z);
        endcase
    end

    always_comb begin
        next_res.wr_en     = 1'b0;
        next_res.rd        = dec_op.rd;
        next_res.rd_hi     = dec_op.rd_hi;
        next_res.wide      = dec_op.wide;
        next_res.result    = alu_sized;
        next_res.flags_wr  = 1'b0;
        next_res.flags     = alu_flags;
        next_res.br_taken  = 1'b0;
        next_res.br_target = cur_pc + W'(4) + dec_op.imm;
        next_res.illegal   = dec_op.illegal;
        case (dec_op.opclass)
            v33_pkg::OP_MOV: begin
                next_res.wr_en  = 1'b1;
                next_res.result = op_b;
            end
            v33_pkg::OP_ALU: begin
                next_res.wr_en    = dec_op.alu_op != v33_pkg::ALU_CMP;
                next_res.flags_wr = 1'b1;
            end
            v33_pkg::OP_BR_REL: next_res.br_taken = 1'b1;
            v33_pkg::OP_B_COND: next_res.br_taken = cond_ok;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_res <= next_res;
    end

    no_write_on_branch: assert property (
        @(posedge clk) disable iff (reset)
        ex_valid |-> !(ex_res.wr_en && ex_res.br_taken)
    );

endmodule

`default_nettype wire

// ==== verilog/v33_params.svh ====
`ifndef V33_PARAMS_SVH
`define V33_PARAMS_SVH

// Datapath
`define V33_DATA_W   16
`define V33_NUM_REGS 8

// Raw instruction word, one per accepted cycle
`define V33_INSTR_W  32

// Decode, execute and writeback stages
`define V33_LATENCY  3

`endif

// ==== verilog/v33_pkg.sv ====
`default_nettype none

`include "v33_params.svh"

package v33_pkg;

    localparam int REG_IDX_W = $clog2(`V33_NUM_REGS);

    typedef enum logic [2:0] {
        OP_NOP    = 3'd0,
        OP_MOV    = 3'd1,
        OP_ALU    = 3'd2,
        OP_BR_REL = 3'd3,
        OP_B_COND = 3'd4    // 5..7 reserved
    } opclass_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_CMP = 3'd5      // 6, 7 reserved
    } alu_op_e;

    typedef struct packed {
        logic z;
        logic s;
        logic p;
        logic cy;
        logic v;
    } flags_t;

    typedef struct packed {
        logic [2:0] reg_d;
        logic [2:0] reg_s;
    } instr_regs_t;

    typedef struct packed {
        logic [3:0] cond;
        logic [1:0] rsvd;
    } instr_br_t;

    // Branches carry the condition in place of the register numbers
    typedef union packed {
        instr_regs_t regs;
        instr_br_t   br;
    } instr_opnd_u;

    typedef struct packed {
        logic [2:0]                            opclass;  // raw, may be reserved
        logic [2:0]                            alu_op;
        logic                                  wide;
        logic                                  use_imm;
        instr_opnd_u                           opnd;
        logic [`V33_INSTR_W-`V33_DATA_W-15:0]  pad;
        logic [`V33_DATA_W-1:0]                imm;
    } instr_t;

    typedef struct packed {
        opclass_e               opclass;
        alu_op_e                alu_op;
        logic                   wide;
        logic [REG_IDX_W-1:0]   rd;
        logic                   rd_hi;
        logic [REG_IDX_W-1:0]   rs;
        logic                   rs_hi;
        logic                   use_imm;
        logic [`V33_DATA_W-1:0] imm;
        logic [3:0]             cond;
        logic                   illegal;
    } decoded_t;

    typedef struct packed {
        logic                   wr_en;
        logic [REG_IDX_W-1:0]   rd;
        logic                   rd_hi;
        logic                   wide;
        logic [`V33_DATA_W-1:0] result;     // byte ops in the low byte
        logic                   flags_wr;
        flags_t                 flags;
        logic                   br_taken;
        logic [`V33_DATA_W-1:0] br_target;
        logic                   illegal;
    } exec_result_t;

    typedef struct packed {
        logic                   reg_written;
        logic [REG_IDX_W-1:0]   reg_index;  // physical register
        logic [`V33_DATA_W-1:0] reg_value;
        flags_t                 flags;
        logic [`V33_DATA_W-1:0] pc;
        logic                   illegal;
    } retire_t;

endpackage

`default_nettype wire

// ==== verilog/v33_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "v33_params.svh"

module v33_writeback (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     ex_valid,
    input  v33_pkg::exec_result_t                    ex_res,
    output logic [`V33_NUM_REGS-1:0][`V33_DATA_W-1:0] regs,
    output v33_pkg::flags_t                          flags,
    output logic [`V33_DATA_W-1:0]                   pc,
    output logic                                     retire_valid,
    output v33_pkg::retire_t                         retire
);

    localparam int W = `V33_DATA_W;

    logic [W-1:0]    old_word;
    logic [W-1:0]    new_word;
    logic [W-1:0]    next_pc;
    v33_pkg::flags_t next_flags;

    assign old_word = regs[ex_res.rd];

    // Byte writes keep the other half of the register
    always_comb begin
        new_word = old_word;
        if (ex_res.wide)
            new_word = ex_res.result;
        else if (ex_res.rd_hi)
            new_word[W-1:8] = ex_res.result[7:0];
        else
            new_word[7:0] = ex_res.result[7:0];
    end

    assign next_flags = ex_res.flags_wr ? ex_res.flags : flags;
    assign next_pc    = ex_res.br_taken ? ex_res.br_target : pc + W'(4);

    always_ff @(posedge clk) begin
        if (reset) begin
            regs  <= '0;
            flags <= '0;
            pc    <= '0;
        end else if (ex_valid) begin
            if (ex_res.wr_en) begin
                regs[ex_res.rd] <= new_word;
            end
            flags <= next_flags;
            pc    <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= ex_valid;
        end
    end

    // Record shows the state as committed on this same edge
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            retire.reg_written <= ex_res.wr_en;
            retire.reg_index   <= ex_res.rd;
            retire.reg_value   <= ex_res.wr_en ? new_word : old_word;
            retire.flags       <= next_flags;
            retire.pc          <= next_pc;
            retire.illegal     <= ex_res.illegal;
        end
    end

    // Pipeline is empty for a full latency after reset is released
    no_early_retire: assert property (
        @(posedge clk)
        $fell(reset) |-> !retire_valid [*`V33_LATENCY]
    );

endmodule

`default_nettype wire
